// ==== Makefile ====
# verilator build and run of the csr unit testbench

VERILATOR ?= verilator
TOP       ?= tb_csr_unit
OBJ_DIR   ?= obj_dir
FILELIST  ?= build.f
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

SOURCES := $(wildcard logic/*.sv logic/*.svh tests/*.sv tests/*.svh)
BIN     := $(OBJ_DIR)/$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -o $(TOP) -f $(FILELIST)

# exit status of the binary is the test result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

// ==== build.f ====
+incdir+logic
+incdir+tests
logic/csr_pkg.sv
logic/perf_pkg.sv
logic/perf_event_stage.sv
logic/perf_counter_bank.sv
logic/machine_csrs.sv
logic/csr_unit_top.sv
tests/tb_csr_unit.sv

// ==== logic/csr_defines.svh ====
////////////////////
// csr unit constants
// csr addresses, event counts and identity values
////////////////////
`ifndef CSR_DEFINES_SVH
`define CSR_DEFINES_SVH

// machine registers
`define CSR_ADDR_MSTATUS    12'h300
`define CSR_ADDR_MSCRATCH   12'h340
`define CSR_ADDR_MEPC       12'h341
`define CSR_ADDR_MCAUSE     12'h342
`define CSR_ADDR_MCPUID     12'hF00 // read only
`define CSR_ADDR_MIMPID     12'hF01 // read only
`define CSR_ADDR_MHARTID    12'hF10 // read only

// performance counter block
`define CSR_ADDR_PCCR_BASE  12'h780 // counters 780..79E
`define CSR_ADDR_PCCR_ALL   12'h79F // write-all alias
`define CSR_ADDR_PCER       12'h7A0 // event enable
`define CSR_ADDR_PCMR       12'h7A1 // mode, bit 1 saturate, bit 0 enable

`define N_CORE_EVENTS       10
`define N_EXT_EVENTS        2  // external counters, edit to resize the bank
`define N_PERF_CNT          (`N_CORE_EVENTS + `N_EXT_EVENTS)

`define MCPUID_VALUE        32'h0000_0100 // rv32i
`define MIMPID_VALUE        32'h0000_8000 // anonymous source

`endif

// ==== logic/csr_pkg.sv ====
////////////////////
// csr access types
// port widths, access operation and the shared rmw rule
////////////////////
package csr_pkg;

  typedef logic [11:0] csr_addr_t;  // csr address space
  typedef logic [31:0] csr_data_t;  // csr data word
  typedef logic [4:0]  hart_id_t;   // core or cluster id
  typedef logic [5:0]  exc_cause_t; // bit 5 irq flag, 4:0 code

  // access operation from the core
  typedef enum logic [1:0] {
    CSR_OP_NONE  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  // new value of a register after an access
  function automatic csr_data_t csr_rmw(csr_op_e op, csr_data_t old_val, csr_data_t wdata);
    csr_data_t res;
    case (op)
      CSR_OP_WRITE: res = wdata;
      CSR_OP_SET:   res = old_val | wdata;
      CSR_OP_CLEAR: res = old_val & ~wdata; // old bits stay where wdata is 0
      default:      res = old_val;          // none
    endcase
    return res;
  endfunction

endpackage

// ==== logic/csr_unit_top.sv ====
////////////////////
// csr unit top
// machine csrs plus the two-stage counter path
////////////////////
`timescale 1ns/1ps
`include "csr_defines.svh"

module csr_unit_top (
  input  logic                     clk,
  input  logic                     rst_n,
  input  csr_pkg::hart_id_t        core_id_i,
  input  csr_pkg::hart_id_t        cluster_id_i,
  // core csr port
  input  logic                     csr_access_i,
  input  csr_pkg::csr_addr_t       csr_addr_i,
  input  csr_pkg::csr_data_t       csr_wdata_i,
  input  csr_pkg::csr_op_e         csr_op_i,
  output csr_pkg::csr_data_t       csr_rdata_o,
  // exceptions
  output logic                     irq_enable_o,
  output csr_pkg::csr_data_t       epc_o,
  input  csr_pkg::csr_data_t       pc_i,
  input  logic                     save_pc_i,
  input  csr_pkg::exc_cause_t      cause_i,
  input  logic                     save_cause_i,
  // events
  input  logic                     id_valid_i,
  input  logic                     is_decoding_i,
  input  logic                     is_compressed_i,
  input  logic                     imiss_i,
  input  logic                     jump_i,
  input  logic                     branch_i,
  input  logic                     ld_stall_i,
  input  logic                     jr_stall_i,
  input  logic                     mem_load_i,
  input  logic                     mem_store_i,
  input  logic [`N_EXT_EVENTS-1:0] ext_events_i
);

  import csr_pkg::*;
  import perf_pkg::*;

  event_vec_t inc;        // stage 1 to stage 2
  logic       perf_hit;
  csr_data_t  perf_rdata;

  perf_event_stage u_event_stage (
    .clk             (clk),
    .rst_n           (rst_n),
    .id_valid_i      (id_valid_i),
    .is_decoding_i   (is_decoding_i),
    .is_compressed_i (is_compressed_i),
    .imiss_i         (imiss_i),
    .jump_i          (jump_i),
    .branch_i        (branch_i),
    .ld_stall_i      (ld_stall_i),
    .jr_stall_i      (jr_stall_i),
    .mem_load_i      (mem_load_i),
    .mem_store_i     (mem_store_i),
    .ext_events_i    (ext_events_i),
    .inc_o           (inc)
  );

  perf_counter_bank u_counter_bank (
    .clk          (clk),
    .rst_n        (rst_n),
    .inc_i        (inc),
    .csr_access_i (csr_access_i),
    .csr_addr_i   (csr_addr_i),
    .csr_wdata_i  (csr_wdata_i),
    .csr_op_i     (csr_op_i),
    .perf_hit_o   (perf_hit),
    .perf_rdata_o (perf_rdata)
  );

  machine_csrs u_machine_csrs (
    .clk          (clk),
    .rst_n        (rst_n),
    .core_id_i    (core_id_i),
    .cluster_id_i (cluster_id_i),
    .csr_access_i (csr_access_i),
    .csr_addr_i   (csr_addr_i),
    .csr_wdata_i  (csr_wdata_i),
    .csr_op_i     (csr_op_i),
    .perf_hit_i   (perf_hit),
    .perf_rdata_i (perf_rdata),
    .pc_i         (pc_i),
    .save_pc_i    (save_pc_i),
    .cause_i      (cause_i),
    .save_cause_i (save_cause_i),
    .csr_rdata_o  (csr_rdata_o),
    .irq_enable_o (irq_enable_o),
    .epc_o        (epc_o)
  );

endmodule

// ==== logic/machine_csrs.sv ====
////////////////////
// machine csrs
// status, scratch, epc, cause, identity and final read mux
////////////////////
`timescale 1ns/1ps
`include "csr_defines.svh"

module machine_csrs (
  input  logic                clk,
  input  logic                rst_n,
  input  csr_pkg::hart_id_t   core_id_i,
  input  csr_pkg::hart_id_t   cluster_id_i,
  input  logic                csr_access_i,
  input  csr_pkg::csr_addr_t  csr_addr_i,
  input  csr_pkg::csr_data_t  csr_wdata_i,
  input  csr_pkg::csr_op_e    csr_op_i,
  input  logic                perf_hit_i,   // counter block owns the address
  input  csr_pkg::csr_data_t  perf_rdata_i,
  input  csr_pkg::csr_data_t  pc_i,
  input  logic                save_pc_i,
  input  csr_pkg::exc_cause_t cause_i,
  input  logic                save_cause_i,
  output csr_pkg::csr_data_t  csr_rdata_o,
  output logic                irq_enable_o,
  output csr_pkg::csr_data_t  epc_o
);

  import csr_pkg::*;

  logic       irq_enable_q, irq_enable_d; // mstatus.ie
  csr_data_t  mscratch_q, mscratch_d;
  csr_data_t  mepc_q, mepc_d;
  exc_cause_t mcause_q, mcause_d;

  csr_data_t  rdata_int; // machine regs only
  csr_data_t  wdata_int; // after rmw
  logic       we;

  ////////////////////
  // read path
  ////////////////////
  always_comb
  begin
    unique case (csr_addr_i)
      `CSR_ADDR_MSTATUS:  rdata_int = {29'b0, 2'b11, irq_enable_q}; // always m-mode
      `CSR_ADDR_MSCRATCH: rdata_int = mscratch_q;
      `CSR_ADDR_MEPC:     rdata_int = mepc_q;
      `CSR_ADDR_MCAUSE:   rdata_int = {mcause_q[5], 26'b0, mcause_q[4:0]};
      `CSR_ADDR_MCPUID:   rdata_int = `MCPUID_VALUE;
      `CSR_ADDR_MIMPID:   rdata_int = `MIMPID_VALUE;
      `CSR_ADDR_MHARTID:  rdata_int = {22'b0, cluster_id_i, core_id_i};
      default:            rdata_int = '0; // unknown reads 0
    endcase
  end

  assign csr_rdata_o = perf_hit_i ? perf_rdata_i : rdata_int;

  // rmw on the final read data
  assign wdata_int = csr_rmw(csr_op_i, csr_rdata_o, csr_wdata_i);
  assign we        = csr_access_i && (csr_op_i != CSR_OP_NONE);

  ////////////////////
  // write path
  ////////////////////
  always_comb
  begin
    irq_enable_d = irq_enable_q;
    mscratch_d   = mscratch_q;
    mepc_d       = mepc_q;
    mcause_d     = mcause_q;

    if (we)
    begin
      case (csr_addr_i)
        `CSR_ADDR_MSTATUS:  irq_enable_d = wdata_int[0];
        `CSR_ADDR_MSCRATCH: mscratch_d   = wdata_int;
        `CSR_ADDR_MEPC:     mepc_d       = wdata_int;
        `CSR_ADDR_MCAUSE:   mcause_d     = {wdata_int[31], wdata_int[4:0]};
        default: ;          // read only or not here
      endcase
    end

    // exception saves win over the csr write
    if (save_pc_i)
      mepc_d = pc_i;
    if (save_cause_i)
      mcause_d = cause_i;
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      irq_enable_q <= 1'b0;
      mscratch_q   <= '0;
      mepc_q       <= '0;
      mcause_q     <= '0;
    end
    else
    begin
      irq_enable_q <= irq_enable_d;
      mscratch_q   <= mscratch_d;
      mepc_q       <= mepc_d;
      mcause_q     <= mcause_d;
    end
  end

  assign irq_enable_o = irq_enable_q;
  assign epc_o        = mepc_q;

  // op must be defined whenever the core accesses
  a_op_known: assert property (@(posedge clk) disable iff (!rst_n)
    csr_access_i |-> !$isunknown(csr_op_i));

endmodule

// ==== logic/perf_counter_bank.sv ====
////////////////////
// perf counter bank
// counters, enable and mode registers, their csr access
////////////////////
`timescale 1ns/1ps
`include "csr_defines.svh"

module perf_counter_bank (
  input  logic                 clk,
  input  logic                 rst_n,
  input  perf_pkg::event_vec_t inc_i,        // registered requests
  input  logic                 csr_access_i,
  input  csr_pkg::csr_addr_t   csr_addr_i,
  input  csr_pkg::csr_data_t   csr_wdata_i,
  input  csr_pkg::csr_op_e     csr_op_i,
  output logic                 perf_hit_o,   // address is ours
  output csr_pkg::csr_data_t   perf_rdata_o  // old value of addressed reg
);

  import csr_pkg::*;
  import perf_pkg::*;

  localparam int        N_CNT     = `N_PERF_CNT;
  localparam csr_addr_t PCCR_BASE = `CSR_ADDR_PCCR_BASE;

  perf_cnt_t  cnt_q [N_CNT];
  perf_cnt_t  cnt_d [N_CNT];
  event_vec_t pcer_q, pcer_d; // per event enable
  perf_mode_t pcmr_q, pcmr_d; // saturate, global enable

  logic       is_pccr;  // 780..79F
  logic       pccr_all; // 79F alias
  logic       is_pcer;
  logic       is_pcmr;
  logic [4:0] pccr_idx;
  csr_data_t  rmw_val;  // new value for pcer or pcmr

  ////////////////////
  // address decode
  ////////////////////
  always_comb
  begin
    is_pccr  = 1'b0;
    pccr_all = 1'b0;
    is_pcer  = 1'b0;
    is_pcmr  = 1'b0;
    if (csr_access_i)
    begin
      is_pccr  = (csr_addr_i[11:5] == PCCR_BASE[11:5]);
      pccr_all = (csr_addr_i == `CSR_ADDR_PCCR_ALL);
      is_pcer  = (csr_addr_i == `CSR_ADDR_PCER);
      is_pcmr  = (csr_addr_i == `CSR_ADDR_PCMR);
    end
  end

  assign pccr_idx   = csr_addr_i[4:0];
  assign perf_hit_o = is_pccr | is_pcer | is_pcmr;

  // read data, alias reads 0
  always_comb
  begin
    perf_rdata_o = '0;
    if (is_pcer)
      perf_rdata_o[N_CNT-1:0] = pcer_q;
    if (is_pcmr)
      perf_rdata_o[1:0] = pcmr_q;
    for (int i = 0; i < N_CNT; i++)
    begin
      if (is_pccr && !pccr_all && pccr_idx == 5'(i))
        perf_rdata_o = cnt_q[i];
    end
  end

  assign rmw_val = csr_rmw(csr_op_i, perf_rdata_o, csr_wdata_i);

  ////////////////////
  // next state
  ////////////////////
  always_comb
  begin
    for (int i = 0; i < N_CNT; i++)
    begin
      cnt_d[i] = cnt_q[i];
      // gated at the counting edge, hold at all ones when saturating
      if (inc_i[i] && pcer_q[i] && pcmr_q[0] && !(pcmr_q[1] && cnt_q[i] == '1))
        cnt_d[i] = cnt_q[i] + perf_cnt_t'(1);
      // csr write beats the increment, a plain read does not
      if (is_pccr && csr_op_i != CSR_OP_NONE && (pccr_all || pccr_idx == 5'(i)))
        cnt_d[i] = csr_rmw(csr_op_i, cnt_q[i], csr_wdata_i);
    end
    pcer_d = is_pcer ? rmw_val[N_CNT-1:0] : pcer_q;
    pcmr_d = is_pcmr ? rmw_val[1:0] : pcmr_q;
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      cnt_q  <= '{default: '0};
      pcer_q <= '0;
      pcmr_q <= 2'b11; // enabled, saturating
    end
    else
    begin
      cnt_q  <= cnt_d;
      pcer_q <= pcer_d;
      pcmr_q <= pcmr_d;
    end
  end

  // only implemented counters get addressed
  a_pccr_idx: assert property (@(posedge clk) disable iff (!rst_n)
    (is_pccr && !pccr_all) |-> (int'(pccr_idx) < N_CNT));

endmodule

// ==== logic/perf_event_stage.sv ====
////////////////////
// perf event stage
// qualifies core events, registers one increment request each
////////////////////
`timescale 1ns/1ps
`include "csr_defines.svh"

module perf_event_stage (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       id_valid_i,    // id stage done
  input  logic                       is_decoding_i, // controller decoding
  input  logic                       is_compressed_i,
  input  logic                       imiss_i,
  input  logic                       jump_i,
  input  logic                       branch_i,
  input  logic                       ld_stall_i,
  input  logic                       jr_stall_i,
  input  logic                       mem_load_i,
  input  logic                       mem_store_i,
  input  logic [`N_EXT_EVENTS-1:0]   ext_events_i,
  output perf_pkg::event_vec_t       inc_o
);

  import perf_pkg::*;

  logic       id_valid_q; // qualifies instruction events
  event_vec_t ev;         // raw events of this cycle

  ////////////////////
  // event vector
  ////////////////////
  always_comb
  begin
    ev[EV_CYCLES]     = 1'b1;
    ev[EV_INSTR]      = id_valid_i & is_decoding_i;
    ev[EV_LD_STALL]   = ld_stall_i & id_valid_q;
    ev[EV_JR_STALL]   = jr_stall_i & id_valid_q;
    ev[EV_IMISS]      = imiss_i;
    ev[EV_LOAD]       = mem_load_i;
    ev[EV_STORE]      = mem_store_i;
    ev[EV_JUMP]       = jump_i & id_valid_q;
    ev[EV_BRANCH]     = branch_i & id_valid_q;
    ev[EV_COMPRESSED] = id_valid_i & is_decoding_i & is_compressed_i;
    // external events sit above the core ones
    ev[`N_PERF_CNT-1:`N_CORE_EVENTS] = ext_events_i;
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      id_valid_q <= 1'b0;
      inc_o      <= '0;
    end
    else
    begin
      id_valid_q <= id_valid_i;
      inc_o      <= ev; // counted one edge later in the bank
    end
  end

  // decoder flags one control transfer kind per instruction
  a_jump_branch_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(jump_i && branch_i));

endmodule

// ==== logic/perf_pkg.sv ====
////////////////////
// performance counter types
////////////////////
`include "csr_defines.svh"

package perf_pkg;

  typedef logic [31:0]              perf_cnt_t;  // one counter
  typedef logic [`N_PERF_CNT-1:0]   event_vec_t; // core events, then external
  typedef logic [1:0]               perf_mode_t; // bit 1 saturate, bit 0 global enable

  // bit index of each core event in event_vec_t
  typedef enum logic [3:0] {
    EV_CYCLES     = 4'd0,
    EV_INSTR      = 4'd1,
    EV_LD_STALL   = 4'd2, // load use hazard
    EV_JR_STALL   = 4'd3, // jump register hazard
    EV_IMISS      = 4'd4, // fetch miss cycles
    EV_LOAD       = 4'd5,
    EV_STORE      = 4'd6,
    EV_JUMP       = 4'd7,
    EV_BRANCH     = 4'd8,
    EV_COMPRESSED = 4'd9
  } perf_event_e;

endpackage

// ==== tests/tb_csr_ref.svh ====
////////////////////
// csr reference model
// expected register state, reads and access updates
////////////////////
`ifndef TB_CSR_REF_SVH
`define TB_CSR_REF_SVH

localparam csr_addr_t PCCR_BASE = `CSR_ADDR_PCCR_BASE;

logic       mdl_ie;      // mstatus interrupt enable
csr_data_t  mdl_scratch;
csr_data_t  mdl_epc;
exc_cause_t mdl_cause;   // flag plus code
perf_cnt_t  mdl_cnt [`N_PERF_CNT];
event_vec_t mdl_pcer;
perf_mode_t mdl_pcmr;

function automatic void reset_model();
  mdl_ie      = 1'b0;
  mdl_scratch = '0;
  mdl_epc     = '0;
  mdl_cause   = '0;
  mdl_pcer    = '0;
  mdl_pcmr    = 2'b11; // counting on, saturating
  for (int i = 0; i < `N_PERF_CNT; i++)
    mdl_cnt[i] = '0;
endfunction

// new value for write, set, clear, none
function automatic csr_data_t apply_op(input csr_op_e op, input csr_data_t old_v,
                                       input csr_data_t wd);
  case (op)
    CSR_OP_WRITE: return wd;
    CSR_OP_SET:   return old_v | wd;
    CSR_OP_CLEAR: return old_v & ~wd;
    default:      return old_v;
  endcase
endfunction

function automatic csr_data_t expected_read(input csr_addr_t addr);
  csr_data_t v;
  int        idx;
  v   = '0;
  idx = int'(addr[4:0]);
  if (addr[11:5] == PCCR_BASE[11:5])
  begin
    if (addr != `CSR_ADDR_PCCR_ALL && idx < `N_PERF_CNT)
      v = mdl_cnt[idx]; // alias and holes read 0
  end
  else
  begin
    case (addr)
      `CSR_ADDR_MSTATUS:  v = 32'h6 | 32'(mdl_ie);
      `CSR_ADDR_MSCRATCH: v = mdl_scratch;
      `CSR_ADDR_MEPC:     v = mdl_epc;
      `CSR_ADDR_MCAUSE:
      begin
        v     = 32'(mdl_cause[4:0]);
        v[31] = mdl_cause[5]; // interrupt flag
      end
      `CSR_ADDR_MCPUID:   v = `MCPUID_VALUE;
      `CSR_ADDR_MIMPID:   v = `MIMPID_VALUE;
      `CSR_ADDR_MHARTID:  v = (32'(cluster_id_i) << 5) | 32'(core_id_i);
      `CSR_ADDR_PCER:     v = 32'(mdl_pcer);
      `CSR_ADDR_PCMR:     v = 32'(mdl_pcmr);
      default:            v = '0;
    endcase
  end
  return v;
endfunction

// state after the edge that ends this access
function automatic void apply_access(input csr_addr_t addr, input csr_op_e op,
                                     input csr_data_t wd);
  csr_data_t nv;
  int        idx;
  nv  = apply_op(op, expected_read(addr), wd);
  idx = int'(addr[4:0]);
  if (addr == `CSR_ADDR_PCCR_ALL)
  begin
    for (int i = 0; i < `N_PERF_CNT; i++)
      mdl_cnt[i] = apply_op(op, mdl_cnt[i], wd); // every counter at once
  end
  else if (addr[11:5] == PCCR_BASE[11:5])
  begin
    if (idx < `N_PERF_CNT)
      mdl_cnt[idx] = nv;
  end
  else
  begin
    case (addr)
      `CSR_ADDR_MSTATUS:  mdl_ie      = nv[0];
      `CSR_ADDR_MSCRATCH: mdl_scratch = nv;
      `CSR_ADDR_MEPC:     mdl_epc     = nv;
      `CSR_ADDR_MCAUSE:   mdl_cause   = {nv[31], nv[4:0]};
      `CSR_ADDR_PCER:     mdl_pcer    = nv[`N_PERF_CNT-1:0];
      `CSR_ADDR_PCMR:     mdl_pcmr    = nv[1:0];
      default: ;          // read only or unknown
    endcase
  end
endfunction

`endif

// ==== tests/tb_csr_unit.sv ====
////////////////////
// csr unit testbench
// random csr traffic, exception saves and counter events vs model
////////////////////
`timescale 1ns/1ps
`include "csr_defines.svh"

module tb_csr_unit;

  import csr_pkg::*;
  import perf_pkg::*;

  typedef logic [`N_EXT_EVENTS-1:0] ext_vec_t;

  localparam int MAX_CYCLES = 4000; // tests take about 480 cycles

  logic       clk = 1'b0;
  logic       rst_n;
  hart_id_t   core_id_i, cluster_id_i;
  logic       csr_access_i;
  csr_addr_t  csr_addr_i;
  csr_data_t  csr_wdata_i;
  csr_op_e    csr_op_i;
  csr_data_t  csr_rdata_o;
  logic       irq_enable_o;
  csr_data_t  epc_o;
  csr_data_t  pc_i;
  logic       save_pc_i;
  exc_cause_t cause_i;
  logic       save_cause_i;
  logic       id_valid_i, is_decoding_i, is_compressed_i, imiss_i;
  logic       jump_i, branch_i, ld_stall_i, jr_stall_i;
  logic       mem_load_i, mem_store_i;
  ext_vec_t   ext_events_i;

  // counter value known only from the event count
  logic       cnt_load;
  int         cnt_load_idx;
  csr_data_t  cnt_load_val;

  int         cycles = 0;

  `include "tb_csr_ref.svh"

  csr_unit_top dut (.*);

  always #2 clk = ~clk;

  ////////////////////
  // compare process
  ////////////////////
  task automatic compare_value(input string what, input csr_data_t got, input csr_data_t exp);
    if (got !== exp)
    begin
      $display("Error at %0t ns: %s got %h expected %h", $time, what, got, exp);
      $display("Done: errors found");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  // outputs settle after the posedge drive, sample at negedge
  always @(negedge clk)
  begin
    if (!rst_n)
      reset_model();
    else
    begin
      compare_value("irq_enable_o", 32'(irq_enable_o), 32'(mdl_ie));
      compare_value("epc_o", epc_o, mdl_epc);
      if (csr_access_i)
      begin
        if (cnt_load)
          mdl_cnt[cnt_load_idx] = cnt_load_val;
        compare_value($sformatf("read of %h", csr_addr_i), csr_rdata_o,
                      expected_read(csr_addr_i));
        apply_access(csr_addr_i, csr_op_i, csr_wdata_i);
      end
      if (save_pc_i)
        mdl_epc = pc_i;     // save beats the csr write
      if (save_cause_i)
        mdl_cause = cause_i;
    end
  end

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES)
    begin
      $display("timeout after %0d cycles, the test sequence did not finish", cycles);
      $display("Done: errors found");
      $fatal(1, "timeout");
    end
  end

  ////////////////////
  // stimulus tasks
  ////////////////////
  task automatic drive_access(input csr_addr_t addr, input csr_op_e op, input csr_data_t wd);
    @(posedge clk);
    csr_access_i <= 1'b1;
    csr_addr_i   <= addr;
    csr_op_i     <= op;
    csr_wdata_i  <= wd;
    save_pc_i    <= 1'b0;
    save_cause_i <= 1'b0;
    cnt_load     <= 1'b0;
  endtask

  task automatic go_idle(input int n);
    repeat (n)
    begin
      @(posedge clk);
      csr_access_i <= 1'b0;
      csr_op_i     <= CSR_OP_NONE;
      save_pc_i    <= 1'b0;
      save_cause_i <= 1'b0;
      cnt_load     <= 1'b0;
    end
  endtask

  // counter read against a count worked out by the stimulus
  task automatic read_count(input int idx, input csr_data_t exp);
    drive_access(`CSR_ADDR_PCCR_BASE + 12'(idx), CSR_OP_NONE, '0);
    cnt_load     <= 1'b1;
    cnt_load_idx <= idx;
    cnt_load_val <= exp;
  endtask

  task automatic pulse_events();
    int       exp_cnt [`N_PERF_CNT];
    logic     ld, st, jmp, idv, idv_prev;
    ext_vec_t ext;
    csr_data_t mask;
    for (int i = 0; i < `N_PERF_CNT; i++)
      exp_cnt[i] = 0;
    mask = '0;
    mask[EV_LOAD]  = 1'b1;
    mask[EV_STORE] = 1'b1;
    mask[EV_JUMP]  = 1'b1;
    mask[`N_PERF_CNT-1:`N_CORE_EVENTS] = '1; // external ones too
    drive_access(`CSR_ADDR_PCER, CSR_OP_WRITE, mask);
    drive_access(`CSR_ADDR_PCMR, CSR_OP_WRITE, 32'h1);
    go_idle(1);
    idv_prev = 1'b0;
    for (int n = 0; n < 200; n++)
    begin
      ld  = 1'($urandom);
      st  = 1'($urandom);
      jmp = 1'($urandom);
      idv = 1'($urandom);
      ext = ext_vec_t'($urandom);
      @(posedge clk);
      mem_load_i   <= ld;
      mem_store_i  <= st;
      jump_i       <= jmp;
      id_valid_i   <= idv;
      ext_events_i <= ext;
      if (ld)
        exp_cnt[EV_LOAD]++;
      if (st)
        exp_cnt[EV_STORE]++;
      if (jmp && idv_prev)
        exp_cnt[EV_JUMP]++; // id_valid of the cycle before
      for (int k = 0; k < `N_EXT_EVENTS; k++)
        if (ext[k])
          exp_cnt[`N_CORE_EVENTS + k]++;
      idv_prev = idv;
    end
    @(posedge clk);
    mem_load_i   <= 1'b0;
    mem_store_i  <= 1'b0;
    jump_i       <= 1'b0;
    id_valid_i   <= 1'b0;
    ext_events_i <= '0;
    go_idle(3); // drain the event stage
    for (int i = 0; i < `N_PERF_CNT; i++)
      read_count(i, 32'(exp_cnt[i]));
    go_idle(1);
  endtask

  ////////////////////
  // test sequence
  ////////////////////
  initial
  begin
    csr_addr_t a;
    csr_data_t all_val;
    void'($urandom(32'hd935_a22d));
    rst_n = 1'b0;
    core_id_i = hart_id_t'($urandom);
    cluster_id_i = hart_id_t'($urandom);
    csr_access_i = 1'b0;
    csr_addr_i = '0;
    csr_wdata_i = '0;
    csr_op_i = CSR_OP_NONE;
    pc_i = '0;
    save_pc_i = 1'b0;
    cause_i = '0;
    save_cause_i = 1'b0;
    id_valid_i = 1'b0;
    is_decoding_i = 1'b0;
    is_compressed_i = 1'b0;
    imiss_i = 1'b0;
    jump_i = 1'b0;
    branch_i = 1'b0;
    ld_stall_i = 1'b0;
    jr_stall_i = 1'b0;
    mem_load_i = 1'b0;
    mem_store_i = 1'b0;
    ext_events_i = '0;
    cnt_load = 1'b0;
    cnt_load_idx = 0;
    cnt_load_val = '0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    // reset values, identity regs
    drive_access(`CSR_ADDR_MSTATUS, CSR_OP_NONE, '0);
    drive_access(`CSR_ADDR_PCMR, CSR_OP_NONE, '0);
    drive_access(`CSR_ADDR_PCER, CSR_OP_NONE, '0);
    drive_access(`CSR_ADDR_MHARTID, CSR_OP_NONE, '0);
    drive_access(`CSR_ADDR_MCPUID, CSR_OP_NONE, '0);
    drive_access(`CSR_ADDR_MIMPID, CSR_OP_NONE, '0);
    for (int i = 0; i < `N_PERF_CNT; i++)
      drive_access(`CSR_ADDR_PCCR_BASE + 12'(i), CSR_OP_NONE, '0);

    // random rmw traffic
    for (int n = 0; n < 150; n++)
    begin
      case ($urandom_range(0, 4))
        0:       a = `CSR_ADDR_MSCRATCH;
        1:       a = `CSR_ADDR_MSTATUS;
        2:       a = `CSR_ADDR_MCAUSE;
        3:       a = `CSR_ADDR_PCER;
        default: a = `CSR_ADDR_PCCR_BASE + 12'd5;
      endcase
      drive_access(a, csr_op_e'(2'($urandom)), $urandom);
    end
    go_idle(1);

    // exception save against a same cycle write
    drive_access(`CSR_ADDR_MEPC, CSR_OP_WRITE, $urandom);
    pc_i      <= $urandom;
    save_pc_i <= 1'b1;
    drive_access(`CSR_ADDR_MCAUSE, CSR_OP_WRITE, $urandom);
    cause_i      <= exc_cause_t'($urandom);
    save_cause_i <= 1'b1;
    drive_access(`CSR_ADDR_MEPC, CSR_OP_NONE, '0);
    drive_access(`CSR_ADDR_MCAUSE, CSR_OP_NONE, '0);
    go_idle(2);

    // write-all alias, counting off
    all_val = $urandom;
    drive_access(`CSR_ADDR_PCMR, CSR_OP_CLEAR, 32'h1);
    drive_access(`CSR_ADDR_PCCR_ALL, CSR_OP_WRITE, all_val);
    go_idle(1);
    for (int i = 0; i < `N_PERF_CNT; i++)
      drive_access(`CSR_ADDR_PCCR_BASE + 12'(i), CSR_OP_NONE, '0);
    drive_access(`CSR_ADDR_PCCR_ALL, CSR_OP_NONE, '0);
    drive_access(`CSR_ADDR_PCCR_ALL, CSR_OP_WRITE, '0);

    pulse_events();

    // saturation of the cycle counter
    drive_access(`CSR_ADDR_PCCR_BASE, CSR_OP_WRITE, 32'hFFFF_FFF0);
    drive_access(`CSR_ADDR_PCMR, CSR_OP_WRITE, 32'h3);
    drive_access(`CSR_ADDR_PCER, CSR_OP_WRITE, 32'h1);
    go_idle(40);
    read_count(0, 32'hFFFF_FFFF);
    // freeze, one more count at the edge that clears the enable
    drive_access(`CSR_ADDR_PCCR_BASE, CSR_OP_WRITE, 32'h100);
    drive_access(`CSR_ADDR_PCMR, CSR_OP_CLEAR, 32'h1);
    go_idle(3);
    read_count(0, 32'h101);
    go_idle(10);
    read_count(0, 32'h101);
    go_idle(2);

    $display("Done: no errors");
    $finish;
  end

endmodule
